// ==== common/centi_params.svh ====
//######################################
// centipede cabinet I/O constants
// bus widths, register map, response codes
//######################################

`ifndef CENTI_PARAMS_SVH
`define CENTI_PARAMS_SVH

// bus geometry
`define CENTI_ADDR_W 5
`define CENTI_DATA_W 8

// trackball counter width and input synchroniser depth
`define TB_COUNT_W 4
`define SYNC_STAGES 2

// read ports
`define REG_IN0 5'd0
`define REG_IN1 5'd1
`define REG_JOY0 5'd2
`define REG_JOY1 5'd3
`define REG_SW1 5'd4
`define REG_SW2 5'd5

// output latch occupies 8..15, one address per bit
`define REG_OUT_BASE 5'd8
`define REG_STEERCLR 5'd16

// AXI response codes
`define AXIL_OKAY 2'b00
`define AXIL_SLVERR 2'b10

`endif

// ==== common/centi_pkg.sv ====
//######################################
// centipede cabinet I/O types
// vector widths, AXI4-Lite channel structs,
// trackball structs and slave FSM states
//######################################

`include "centi_params.svh"

package centi_pkg;

   typedef logic [`CENTI_ADDR_W-1:0] addr_t;
   typedef logic [`CENTI_DATA_W-1:0] data_t;
   typedef logic [`TB_COUNT_W-1:0] tb_count_t;
   typedef logic [1:0] resp_t;

   // write address, write data and write response ready
   typedef struct packed {
      logic awvalid;
      addr_t awaddr;
      logic wvalid;
      data_t wdata;
      logic bready;
   } axil_wr_req_t;

   typedef struct packed {
      logic awready;
      logic wready;
      logic bvalid;
      resp_t bresp;
   } axil_wr_rsp_t;

   typedef struct packed {
      logic arvalid;
      addr_t araddr;
      logic rready;
   } axil_rd_req_t;

   typedef struct packed {
      logic arready;
      logic rvalid;
      data_t rdata;
      resp_t rresp;
   } axil_rd_rsp_t;

   // raw pins of one trackball axis
   typedef struct packed {
      logic dir;
      logic ck;
   } trak_pins_t;

   typedef struct packed {
      logic dir;
      tb_count_t count;
   } trak_state_t;

   typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
   typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

endpackage

// ==== files.f ====
+incdir+common
common/centi_pkg.sv
trakball/trakball_axis.sv
io_bus/cabinet_latch.sv
io_bus/io_bus_slave.sv
verilog/centi_io_top.sv
tests/tb_centi_io.sv

// ==== io_bus/cabinet_latch.sv ====
//######################################
// coin counter / LED / flip output latch
// coin forcing and player trackball select
//######################################

`timescale 1ns/1ps

module cabinet_latch
(
   input  logic                  s_6mhz,
   input  logic                  reset,
   input  logic                  wr_en_i,
   input  logic [2:0]            bit_sel_i,
   input  logic                  bit_val_i,
   input  logic [7:0]            trakball_i,
   input  logic [9:7]            player_i,
   output logic [4:1]            led_o,
   output logic [2:0]            coins_o,
   output centi_pkg::trak_pins_t h_pins_o,
   output centi_pkg::trak_pins_t v_pins_o
);

   logic [7:0] cc_latch;
   logic flip;

   // one bit per write, addressed by the low address bits
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         cc_latch <= '0;
      else if (wr_en_i)
         cc_latch[bit_sel_i] <= bit_val_i;
   end

   assign flip = cc_latch[7];
   assign led_o = cc_latch[6:3];

   // coin drives OR'd into the raw switches, bit 1 covers both c and l
   assign coins_o[2] = player_i[9] | cc_latch[2];
   assign coins_o[1] = player_i[8] | cc_latch[1];
   assign coins_o[0] = player_i[7] | cc_latch[1];

   // flip selects player 1, else player 2
   always_comb
   begin
      if (flip)
      begin
         h_pins_o.dir = trakball_i[7];
         h_pins_o.ck = trakball_i[5];
         v_pins_o.dir = trakball_i[3];
         v_pins_o.ck = trakball_i[1];
      end
      else
      begin
         h_pins_o.dir = trakball_i[6];
         h_pins_o.ck = trakball_i[4];
         v_pins_o.dir = trakball_i[2];
         v_pins_o.ck = trakball_i[0];
      end
   end

endmodule

// ==== io_bus/io_bus_slave.sv ====
//######################################
// AXI4-Lite slave for the cabinet I/O
// handshakes, address decode, read ports,
// latch and steer-clear strobes
//######################################

`timescale 1ns/1ps

`include "centi_params.svh"

module io_bus_slave
(
   input  logic                    s_6mhz,
   input  logic                    reset,
   input  centi_pkg::axil_wr_req_t wr_req_i,
   input  centi_pkg::axil_rd_req_t rd_req_i,
   input  centi_pkg::trak_state_t  h_i,
   input  centi_pkg::trak_state_t  v_i,
   input  logic [2:0]              coins_i,
   input  logic [6:0]              player_i,
   input  centi_pkg::data_t        joystick_i,
   input  centi_pkg::data_t        sw1_i,
   input  centi_pkg::data_t        sw2_i,
   input  logic                    vblank_i,
   output centi_pkg::axil_wr_rsp_t wr_rsp_o,
   output centi_pkg::axil_rd_rsp_t rd_rsp_o,
   output logic                    latch_wr_o,
   output logic [2:0]              latch_sel_o,
   output logic                    latch_val_o,
   output logic                    steer_clr_o
);

   import centi_pkg::*;

   wr_state_e wr_state;
   rd_state_e rd_state;
   logic wr_accept;
   logic rd_accept;
   logic latch_hit;
   logic steer_hit;
   resp_t bresp_q;
   data_t in0;
   data_t in1;
   data_t joy0;
   data_t rd_port;
   logic rd_ok;
   data_t rdata_q;
   resp_t rresp_q;

   // address and data taken together, only when idle
   assign wr_accept = (wr_state == WR_IDLE) && wr_req_i.awvalid && wr_req_i.wvalid;

   assign latch_hit = (wr_req_i.awaddr >= `REG_OUT_BASE) &&
                      (wr_req_i.awaddr < (`REG_OUT_BASE + 5'd8));
   assign steer_hit = (wr_req_i.awaddr == `REG_STEERCLR);

   assign latch_wr_o = wr_accept && latch_hit;
   assign latch_sel_o = wr_req_i.awaddr[2:0];
   assign latch_val_o = wr_req_i.wdata[7];
   assign steer_clr_o = wr_accept && steer_hit;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         wr_state <= WR_IDLE;
      else
      begin
         case (wr_state)
            WR_IDLE:
               if (wr_accept)
                  wr_state <= WR_RESP;
            WR_RESP:
               if (wr_req_i.bready)
                  wr_state <= WR_IDLE;
            default:
               wr_state <= WR_IDLE;
         endcase
      end
   end

   always_ff @(posedge s_6mhz)
   begin
      if (wr_accept)
         bresp_q <= (latch_hit || steer_hit) ? `AXIL_OKAY : `AXIL_SLVERR;
   end

   always_comb
   begin
      wr_rsp_o.awready = wr_accept;
      wr_rsp_o.wready = wr_accept;
      wr_rsp_o.bvalid = (wr_state == WR_RESP);
      wr_rsp_o.bresp = bresp_q;
   end

   // read ports in the cabinet bit order
   assign in0 = {h_i.dir, vblank_i, player_i[6], player_i[5], h_i.count};
   assign in1 = {coins_i, player_i[4], player_i[1], player_i[0], player_i[3], player_i[2]};
   assign joy0 = {v_i.dir, 3'b000, v_i.count};

   always_comb
   begin
      rd_ok = 1'b1;
      case (rd_req_i.araddr)
         `REG_IN0:  rd_port = in0;
         `REG_IN1:  rd_port = in1;
         `REG_JOY0: rd_port = joy0;
         `REG_JOY1: rd_port = joystick_i;
         `REG_SW1:  rd_port = sw1_i;
         `REG_SW2:  rd_port = sw2_i;
         default:
         begin
            rd_port = '0;
            rd_ok = 1'b0;
         end
      endcase
   end

   assign rd_accept = (rd_state == RD_IDLE) && rd_req_i.arvalid;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         rd_state <= RD_IDLE;
      else
      begin
         case (rd_state)
            RD_IDLE:
               if (rd_accept)
                  rd_state <= RD_DATA;
            RD_DATA:
               if (rd_req_i.rready)
                  rd_state <= RD_IDLE;
            default:
               rd_state <= RD_IDLE;
         endcase
      end
   end

   // port sampled at acceptance, held until rready
   always_ff @(posedge s_6mhz)
   begin
      if (rd_accept)
      begin
         rdata_q <= rd_port;
         rresp_q <= rd_ok ? `AXIL_OKAY : `AXIL_SLVERR;
      end
   end

   always_comb
   begin
      rd_rsp_o.arready = (rd_state == RD_IDLE);
      rd_rsp_o.rvalid = (rd_state == RD_DATA);
      rd_rsp_o.rdata = rdata_q;
      rd_rsp_o.rresp = rresp_q;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cabinet I/O testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_centi_io \
   --Mdir obj_dir -o tb_centi_io || exit 1

out="$(./obj_dir/tb_centi_io)"
echo "$out"

echo "$out" | grep -qx "Simulation PASSED" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_centi_io.sv ====
//########################################
// cabinet I/O testbench
// AXI4-Lite traffic checked against a
// model of the latch and trackball counts
//########################################

`timescale 1ns/1ps

`include "centi_params.svh"

module tb_centi_io;

   import centi_pkg::*;

   localparam int TIMEOUT_CYCLES = 4000;

   logic s_6mhz;
   logic reset;
   axil_wr_req_t wr_req;
   axil_wr_rsp_t wr_rsp;
   axil_rd_req_t rd_req;
   axil_rd_rsp_t rd_rsp;
   logic [9:0] player;
   logic [7:0] trakball;
   data_t joystick;
   data_t sw1;
   data_t sw2;
   logic vblank;
   logic [4:1] led;

   integer seed = 21;
   int value_errs = 0;
   int proto_errs = 0;
   int cycles = 0;

   // reference model
   logic [7:0] model_latch;
   tb_count_t model_h_count;
   tb_count_t model_v_count;
   logic model_h_dir;
   logic model_v_dir;

   centi_io_top dut_i
   (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .wr_req_i   (wr_req),
      .wr_rsp_o   (wr_rsp),
      .rd_req_i   (rd_req),
      .rd_rsp_o   (rd_rsp),
      .player_i   (player),
      .trakball_i (trakball),
      .joystick_i (joystick),
      .sw1_i      (sw1),
      .sw2_i      (sw2),
      .vblank_i   (vblank),
      .led_o      (led)
   );

   initial
   begin
      s_6mhz = 1'b0;
      forever
         #5 s_6mhz = ~s_6mhz;
   end

   always @(posedge s_6mhz)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // responses hold with stable payload until taken
   assert property (@(posedge s_6mhz) disable iff (reset)
      wr_rsp.bvalid && !wr_req.bready |=> wr_rsp.bvalid && $stable(wr_rsp.bresp))
   else
   begin
      proto_errs++;
      $display("bvalid dropped or bresp changed before bready at %0t", $time);
   end

   assert property (@(posedge s_6mhz) disable iff (reset)
      rd_rsp.rvalid && !rd_req.rready |=> rd_rsp.rvalid && $stable(rd_rsp.rdata)
      && $stable(rd_rsp.rresp))
   else
   begin
      proto_errs++;
      $display("rvalid dropped or read data changed before rready at %0t", $time);
   end

   // no new request taken while a response is pending
   assert property (@(posedge s_6mhz) disable iff (reset)
      wr_rsp.bvalid |-> !wr_rsp.awready && !wr_rsp.wready)
   else
   begin
      proto_errs++;
      $display("write accepted while a write response was pending at %0t", $time);
   end

   assert property (@(posedge s_6mhz) disable iff (reset) rd_rsp.rvalid |-> !rd_rsp.arready)
   else
   begin
      proto_errs++;
      $display("read accepted while read data was pending at %0t", $time);
   end

   assert property (@(posedge s_6mhz) disable iff (reset) wr_rsp.awready == wr_rsp.wready)
   else
   begin
      proto_errs++;
      $display("awready and wready disagree at %0t", $time);
   end

   task automatic check_val(input string name, input data_t exp, input data_t got);
      assert (got === exp)
      else
      begin
         value_errs++;
         $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   function automatic logic random_bit();
      int r;
      r = $random(seed);
      return r[0];
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n)
         @(posedge s_6mhz);
   endtask

   function automatic data_t exp_in0();
      return {model_h_dir, vblank, player[6], player[5], model_h_count};
   endfunction

   // coin_r, coin_c, coin_l, slam, fire2, fire1, start1, start2
   function automatic data_t exp_in1();
      return {player[9] | model_latch[2], player[8] | model_latch[1],
              player[7] | model_latch[1], player[4], player[1], player[0],
              player[3], player[2]};
   endfunction

   function automatic data_t exp_joy0();
      return {model_v_dir, 3'b000, model_v_count};
   endfunction

   task automatic bus_write(input addr_t addr, input data_t data);
      logic done;
      resp_t exp_resp;
      exp_resp = (addr >= `REG_OUT_BASE && addr <= `REG_STEERCLR) ? `AXIL_OKAY : `AXIL_SLVERR;
      @(posedge s_6mhz);
      wr_req.awvalid <= 1'b1;
      wr_req.awaddr <= addr;
      wr_req.wvalid <= 1'b1;
      wr_req.wdata <= data;
      do
         @(posedge s_6mhz);
      while (!wr_rsp.awready);
      // request stays up over the response phase so an early accept would show
      wr_req.bready <= random_bit();
      done = 1'b0;
      while (!done)
      begin
         @(posedge s_6mhz);
         done = wr_rsp.bvalid && wr_req.bready;
         if (!done)
            wr_req.bready <= random_bit();
      end
      wr_req.awvalid <= 1'b0;
      wr_req.wvalid <= 1'b0;
      wr_req.bready <= 1'b0;
      check_val("bresp", 8'(exp_resp), 8'(wr_rsp.bresp));
      if (addr >= `REG_OUT_BASE && addr < `REG_STEERCLR)
         model_latch[addr[2:0]] = data[7];
      else if (addr == `REG_STEERCLR)
      begin
         model_h_count = '0;
         model_v_count = '0;
      end
   endtask

   // unmapped addresses are checked for zero data here
   task automatic bus_read(input addr_t addr, output data_t data);
      logic done;
      resp_t exp_resp;
      exp_resp = (addr <= `REG_SW2) ? `AXIL_OKAY : `AXIL_SLVERR;
      @(posedge s_6mhz);
      rd_req.arvalid <= 1'b1;
      rd_req.araddr <= addr;
      do
         @(posedge s_6mhz);
      while (!rd_rsp.arready);
      rd_req.arvalid <= 1'b0;
      rd_req.rready <= random_bit();
      done = 1'b0;
      while (!done)
      begin
         @(posedge s_6mhz);
         done = rd_rsp.rvalid && rd_req.rready;
         if (!done)
            rd_req.rready <= random_bit();
      end
      rd_req.rready <= 1'b0;
      data = rd_rsp.rdata;
      check_val("rresp", 8'(exp_resp), 8'(rd_rsp.rresp));
      if (addr > `REG_SW2)
         check_val("rdata unmapped", 8'h00, data);
   endtask

   task automatic check_led();
      check_val("led_o", {4'h0, model_latch[6:3]}, {4'h0, led});
   endtask

   task automatic check_trak();
      data_t got;
      bus_read(`REG_IN0, got);
      check_val("rdata IN0", exp_in0(), got);
      bus_read(`REG_JOY0, got);
      check_val("rdata JOY0", exp_joy0(), got);
   endtask

   task automatic randomize_inputs();
      @(posedge s_6mhz);
      player <= 10'($random(seed));
      joystick <= 8'($random(seed));
      sw1 <= 8'($random(seed));
      sw2 <= 8'($random(seed));
      vblank <= random_bit();
   endtask

   // p1 picks player 1 pins, dir settles before the ck edge
   task automatic trak_pulse(input logic p1, input logic vert, input logic dir);
      int dir_pos;
      int ck_pos;
      dir_pos = (vert ? 2 : 6) + (p1 ? 1 : 0);
      ck_pos = (vert ? 0 : 4) + (p1 ? 1 : 0);
      @(posedge s_6mhz);
      trakball[dir_pos] <= dir;
      wait_cycles(4);
      trakball[ck_pos] <= 1'b1;
      wait_cycles(4);
      trakball[ck_pos] <= 1'b0;
      wait_cycles(8);
      // only the selected player's pins reach the counters
      if (p1 == model_latch[7])
      begin
         if (vert)
         begin
            model_v_dir = dir;
            model_v_count = dir ? model_v_count + 4'd1 : model_v_count - 4'd1;
         end
         else
         begin
            model_h_dir = dir;
            model_h_count = dir ? model_h_count + 4'd1 : model_h_count - 4'd1;
         end
      end
   endtask

   task automatic pulse_train(input logic p1, input logic vert, input logic dir, input int n);
      repeat (n)
         trak_pulse(p1, vert, dir);
   endtask

   initial
   begin
      data_t got;
      addr_t addr;
      reset <= 1'b1;
      wr_req <= '0;
      rd_req <= '0;
      player <= '0;
      trakball <= '0;
      joystick <= '0;
      sw1 <= '0;
      sw2 <= '0;
      vblank <= 1'b0;
      model_latch = '0;
      model_h_count = '0;
      model_v_count = '0;
      model_h_dir = 1'b0;
      model_v_dir = 1'b0;
      repeat (3)
         @(posedge s_6mhz);
      reset <= 1'b0;
      @(posedge s_6mhz);
      check_val("awready", 8'h00, 8'(wr_rsp.awready));
      check_val("wready", 8'h00, 8'(wr_rsp.wready));
      check_val("bvalid", 8'h00, 8'(wr_rsp.bvalid));
      check_val("rvalid", 8'h00, 8'(rd_rsp.rvalid));
      check_val("arready", 8'h01, 8'(rd_rsp.arready));
      check_led();

      // plain read ports with random inputs
      repeat (6)
      begin
         randomize_inputs();
         bus_read(`REG_SW1, got);
         check_val("rdata SW1", sw1, got);
         bus_read(`REG_SW2, got);
         check_val("rdata SW2", sw2, got);
         bus_read(`REG_JOY1, got);
         check_val("rdata JOY1", joystick, got);
         bus_read(`REG_IN1, got);
         check_val("rdata IN1", exp_in1(), got);
         check_trak();
      end

      // led bits 3..6
      repeat (12)
      begin
         addr = `REG_OUT_BASE + 5'(3 + {$random(seed)} % 4);
         bus_write(addr, 8'($random(seed)));
         check_led();
      end

      // coin drives, raw coin switches held low
      @(posedge s_6mhz);
      player[9:7] <= 3'b000;
      bus_write(`REG_OUT_BASE + 5'd2, 8'h80);
      bus_read(`REG_IN1, got);
      check_val("rdata IN1", exp_in1(), got);
      bus_write(`REG_OUT_BASE + 5'd1, 8'h80);
      bus_read(`REG_IN1, got);
      check_val("rdata IN1", exp_in1(), got);
      bus_write(`REG_OUT_BASE + 5'd2, 8'h00);
      bus_write(`REG_OUT_BASE + 5'd1, 8'h00);
      bus_read(`REG_IN1, got);
      check_val("rdata IN1", exp_in1(), got);
      check_led();

      // flip clear, player 2 pins drive both axes
      pulse_train(1'b0, 1'b0, 1'b1, 5);
      pulse_train(1'b0, 1'b0, 1'b0, 2);
      pulse_train(1'b0, 1'b1, 1'b0, 3);
      pulse_train(1'b0, 1'b1, 1'b1, 1);
      check_trak();
      pulse_train(1'b0, 1'b0, 1'b0, 4);
      check_trak();
      @(posedge s_6mhz);
      vblank <= ~vblank;
      check_trak();
      @(posedge s_6mhz);
      vblank <= ~vblank;
      check_trak();
      pulse_train(1'b1, 1'b0, 1'b1, 2);
      check_trak();

      // steer clear keeps dir, then flip hands the axes to player 1
      bus_write(`REG_STEERCLR, 8'h00);
      check_trak();
      bus_write(`REG_OUT_BASE + 5'd7, 8'h80);
      pulse_train(1'b1, 1'b0, 1'b1, 3);
      pulse_train(1'b1, 1'b1, 1'b0, 2);
      pulse_train(1'b0, 1'b0, 1'b1, 2);
      check_trak();
      bus_write(`REG_OUT_BASE + 5'd7, 8'h00);
      pulse_train(1'b0, 1'b1, 1'b1, 1);
      check_trak();

      // unmapped addresses
      bus_write(5'd6, 8'hff);
      bus_write(5'd17, 8'hff);
      bus_read(5'd7, got);
      bus_read(5'd20, got);
      check_led();

      wait_cycles(4);
      $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
      if (value_errs + proto_errs == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== trakball/trakball_axis.sv ====
//######################################
// one trackball axis
// synchronised ck/dir, 4-bit up/down count
//######################################

`timescale 1ns/1ps

`include "centi_params.svh"

module trakball_axis
(
   input  logic                   s_6mhz,
   input  logic                   reset,
   input  centi_pkg::trak_pins_t  pins_i,
   input  logic                   clear_i,
   output centi_pkg::trak_state_t state_o
);

   import centi_pkg::*;

   logic [`SYNC_STAGES-1:0] dir_sync;
   logic [`SYNC_STAGES-1:0] ck_sync;
   logic ck_prev;
   logic ck_rise;
   logic dir_now;
   logic dir_q;
   tb_count_t count_q;

   // both pins go through the same depth so they stay aligned
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         dir_sync <= '0;
         ck_sync <= '0;
         ck_prev <= 1'b0;
      end
      else
      begin
         dir_sync <= {dir_sync[`SYNC_STAGES-2:0], pins_i.dir};
         ck_sync <= {ck_sync[`SYNC_STAGES-2:0], pins_i.ck};
         ck_prev <= ck_sync[`SYNC_STAGES-1];
      end
   end

   assign ck_rise = ck_sync[`SYNC_STAGES-1] & ~ck_prev;
   assign dir_now = dir_sync[`SYNC_STAGES-1];

   // steps by the direction seen on the same ck edge
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         dir_q <= 1'b0;
         count_q <= '0;
      end
      else
      begin
         if (ck_rise)
            dir_q <= dir_now;
         // steer clear wins over a step
         if (clear_i)
            count_q <= '0;
         else if (ck_rise)
         begin
            if (dir_now)
               count_q <= count_q + 1'b1;
            else
               count_q <= count_q - 1'b1;
         end
      end
   end

   assign state_o.dir = dir_q;
   assign state_o.count = count_q;

endmodule

// ==== verilog/centi_io_top.sv ====
//######################################
// centipede cabinet I/O peripheral
// AXI4-Lite slave over the player inputs,
// trackballs, switches and output latch
//######################################

`timescale 1ns/1ps

module centi_io_top
(
   input  logic                    s_6mhz,
   input  logic                    reset,
   input  centi_pkg::axil_wr_req_t wr_req_i,
   output centi_pkg::axil_wr_rsp_t wr_rsp_o,
   input  centi_pkg::axil_rd_req_t rd_req_i,
   output centi_pkg::axil_rd_rsp_t rd_rsp_o,
   input  logic [9:0]              player_i,
   input  logic [7:0]              trakball_i,
   input  centi_pkg::data_t        joystick_i,
   input  centi_pkg::data_t        sw1_i,
   input  centi_pkg::data_t        sw2_i,
   input  logic                    vblank_i,
   output logic [4:1]              led_o
);

   import centi_pkg::*;

   logic latch_wr;
   logic [2:0] latch_sel;
   logic latch_val;
   logic steer_clr;
   logic [2:0] coins;
   trak_pins_t h_pins;
   trak_pins_t v_pins;
   trak_state_t h_state;
   trak_state_t v_state;

   cabinet_latch cab_latch
   (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .wr_en_i    (latch_wr),
      .bit_sel_i  (latch_sel),
      .bit_val_i  (latch_val),
      .trakball_i (trakball_i),
      .player_i   (player_i[9:7]),
      .led_o      (led_o),
      .coins_o    (coins),
      .h_pins_o   (h_pins),
      .v_pins_o   (v_pins)
   );

   trakball_axis trak_h
   (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .pins_i  (h_pins),
      .clear_i (steer_clr),
      .state_o (h_state)
   );

   trakball_axis trak_v
   (
      .s_6mhz  (s_6mhz),
      .reset   (reset),
      .pins_i  (v_pins),
      .clear_i (steer_clr),
      .state_o (v_state)
   );

   io_bus_slave bus_slave
   (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .wr_req_i    (wr_req_i),
      .rd_req_i    (rd_req_i),
      .h_i         (h_state),
      .v_i         (v_state),
      .coins_i     (coins),
      .player_i    (player_i[6:0]),
      .joystick_i  (joystick_i),
      .sw1_i       (sw1_i),
      .sw2_i       (sw2_i),
      .vblank_i    (vblank_i),
      .wr_rsp_o    (wr_rsp_o),
      .rd_rsp_o    (rd_rsp_o),
      .latch_wr_o  (latch_wr),
      .latch_sel_o (latch_sel),
      .latch_val_o (latch_val),
      .steer_clr_o (steer_clr)
   );

endmodule
